//--- rtp_pkg.sv
// types and constants shared by the NS2009 polling front end
// coordinates are raw 12-bit ADC codes with no filtering or calibration
package rtp_pkg;

    // one finished frame as handed to the consumer
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] z1;       // touch pressure reading
        logic        pressed;  // z1 above threshold
    } rtp_sample_t;

    // 7-bit address, 0x90 on the wire for writes and 0x91 for reads
    localparam logic [6:0] rtp_dev_addr = 7'h48;

    // NS2009 conversion commands
    localparam logic [7:0] rtp_cmd_x  = 8'hC0;  // measure x
    localparam logic [7:0] rtp_cmd_y  = 8'hD0;  // measure y
    localparam logic [7:0] rtp_cmd_z1 = 8'hE0;  // measure z1

    // conversion order within one frame
    typedef enum logic [1:0] {
        chan_x,
        chan_y,
        chan_z1
    } rtp_chan_e;

endpackage

//--- rtp_xfer_if.sv
`timescale 1ns/1ps
// one I2C transfer request and its result between sequencer and master
// req is a level held until done and dropped in the cycle after it
interface rtp_xfer_if ();

    logic        req;    // held high until done
    logic        rw;     // 0 writes cmd, 1 reads two bytes
    logic [7:0]  cmd;    // command byte, used on writes only
    logic        done;   // single cycle at the end of the stop condition
    logic        nack;   // valid with done
    logic [11:0] rdata;  // valid with done on reads

    // sequencer side
    modport seq (
        output req,
        output rw,
        output cmd,
        input  done,
        input  nack,
        input  rdata
    );

    // bit engine side
    modport mst (
        input  req,
        input  rw,
        input  cmd,
        output done,
        output nack,
        output rdata
    );

endinterface

//--- rtp_tick_gen.sv
`timescale 1ns/1ps
// quarter-bit strobes for the I2C master, needs clk_div >= 2
// the counter sits at zero while run is low so the first bit is full length
module rtp_tick_gen #(
    parameter int unsigned clk_div = 62  // clocks per SCL quarter phase
) (
    input  logic clk,
    input  logic arst_n,
    input  logic run,
    output logic tick,
    output logic mid_tick
);

    localparam int unsigned cw = $clog2(clk_div);

    logic [cw-1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (!run || tick) begin
            cnt <= '0;                      // restart on idle and on every wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // wrap ends one quarter, the master steps its phase on it
    assign tick = (cnt == cw'(clk_div - 1));

    // roughly the centre of a quarter, used for sampling SDA
    assign mid_tick = (cnt == cw'(clk_div / 2));

endmodule

//--- rtp_i2c_master.sv
`timescale 1ns/1ps
// open-drain I2C byte engine, write of one command byte or read of two bytes
// single master only, no clock stretching and no repeated start
// scl_in and sda_in are used directly, synchronize them outside if the pads are async
// oe = 1 pulls a line low, oe = 0 releases it to the pull-up
module rtp_i2c_master (
    input  logic    clk,
    input  logic    arst_n,
    rtp_xfer_if.mst xfer,
    input  logic    tick,
    input  logic    mid_tick,
    output logic    busy,
    output logic    scl_oe,
    output logic    sda_oe,
    input  logic    scl_in,
    input  logic    sda_in
);
    import rtp_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_bits,
        st_stop
    } state_e;

    state_e      state;
    logic [1:0]  qtr;        // quarter within the current bit
    logic [3:0]  bit_cnt;    // 0..7 data bits, 8 is the ack slot
    logic [1:0]  byte_cnt;   // 0 address, 1 cmd or high byte, 2 low byte
    logic        rw;
    logic        nack_seen;
    logic [7:0]  cmd;
    logic [7:0]  tx_sh;      // outgoing byte, msb first
    logic [15:0] rx_sh;      // both read bytes
    logic        launch;
    logic        ack_slot;
    logic        rd_data;    // current byte is driven by the slave
    logic        last_byte;
    logic        sample;
    logic        bit_end;
    logic        stop_end;

    // done is still high in the last cycle req is held, so skip that cycle
    assign launch    = (state == st_idle) && xfer.req && !xfer.done;
    assign ack_slot  = (bit_cnt == 4'd8);
    assign rd_data   = rw && (byte_cnt != 2'd0);
    assign last_byte = (byte_cnt == (rw ? 2'd2 : 2'd1));
    assign sample    = (state == st_bits) && mid_tick && (qtr == 2'd2);  // scl high
    assign bit_end   = (state == st_bits) && tick && (qtr == 2'd3);
    assign stop_end  = (state == st_stop) && tick && (qtr == 2'd3);

    // per bit: q0 scl falls, q1 sda changes, q2 scl rises, q3 scl stays high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            qtr       <= 2'd0;
            bit_cnt   <= 4'd0;
            byte_cnt  <= 2'd0;
            rw        <= 1'b0;
            nack_seen <= 1'b0;
            busy      <= 1'b0;
            scl_oe    <= 1'b0;
            sda_oe    <= 1'b0;
            xfer.done <= 1'b0;
            xfer.nack <= 1'b0;
        end else begin
            xfer.done <= 1'b0;
            if (tick && state != st_idle)
                qtr <= qtr + 1'b1;

            case (state)
                st_idle: begin
                    if (launch) begin
                        state     <= st_start;
                        busy      <= 1'b1;        // starts the tick counter
                        qtr       <= 2'd0;
                        bit_cnt   <= 4'd0;
                        byte_cnt  <= 2'd0;
                        rw        <= xfer.rw;
                        nack_seen <= 1'b0;
                    end
                end

                st_start: begin
                    if (tick && qtr == 2'd1)
                        sda_oe <= 1'b1;           // sda falls while scl is high
                    if (tick && qtr == 2'd3) begin
                        scl_oe <= 1'b1;
                        state  <= st_bits;
                    end
                end

                st_bits: begin
                    // slave ack slots only, a low scl here also counts as no ack
                    if (sample && ack_slot && !rd_data)
                        nack_seen <= sda_in || !scl_in;
                    if (tick) begin
                        case (qtr)
                            2'd0: begin
                                if (ack_slot)
                                    sda_oe <= rw && (byte_cnt == 2'd1);  // ack high byte only
                                else
                                    sda_oe <= !rd_data && !tx_sh[7];
                            end
                            2'd1: scl_oe <= 1'b0;
                            2'd3: begin
                                scl_oe <= 1'b1;
                                if (!ack_slot) begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                end else begin
                                    bit_cnt <= 4'd0;
                                    if (nack_seen || last_byte)
                                        state <= st_stop;
                                    else
                                        byte_cnt <= byte_cnt + 1'b1;
                                end
                            end
                            default: ;
                        endcase
                    end
                end

                st_stop: begin
                    if (tick) begin
                        case (qtr)
                            2'd0: sda_oe <= 1'b1;   // scl is low, pull sda down first
                            2'd1: scl_oe <= 1'b0;
                            2'd2: sda_oe <= 1'b0;   // sda rises while scl is high
                            default: begin
                                state     <= st_idle;
                                busy      <= 1'b0;
                                xfer.done <= 1'b1;
                                xfer.nack <= nack_seen;
                            end
                        endcase
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    // shift registers and result
    always_ff @(posedge clk) begin
        if (launch) begin
            cmd   <= xfer.cmd;
            tx_sh <= {rtp_dev_addr, xfer.rw};     // address byte with r/w bit
        end else if (bit_end) begin
            tx_sh <= ack_slot ? cmd : {tx_sh[6:0], 1'b0};
        end
        if (sample && rd_data && !ack_slot)
            rx_sh <= {rx_sh[14:0], sda_in};
        if (stop_end)
            xfer.rdata <= rx_sh[15:4];            // high byte and top nibble of low byte
    end

endmodule

//--- rtp_poll_seq.sv
`timescale 1ns/1ps
// frame sequencer, x then y then z1, each a command write followed by a read
// buf_full is checked only when a frame is about to start
// a NACK drops the whole frame, nack_count saturates at 255
module rtp_poll_seq #(
    parameter int unsigned poll_gap     = 25000,   // idle clocks between frames
    parameter logic [11:0] press_thresh = 12'h200
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 enable,
    rtp_xfer_if.seq              xfer,
    output logic                 push,
    output rtp_pkg::rtp_sample_t push_data,
    input  logic                 buf_full,
    output logic [7:0]           nack_count
);
    import rtp_pkg::*;

    localparam int unsigned   gw       = $clog2(poll_gap + 2);
    localparam logic [gw-1:0] gap_last = gw'((poll_gap > 0) ? poll_gap - 1 : 0);

    typedef enum logic [1:0] {
        st_gap,     // wait out the gap, then start a frame
        st_issue,   // req low for one cycle between transfers
        st_wait
    } state_e;

    state_e        state;
    rtp_chan_e     chan;
    logic [gw-1:0] gap_cnt;
    logic [11:0]   x_q;
    logic [11:0]   y_q;
    logic          rd_ok;

    assign rd_ok = (state == st_wait) && xfer.done && !xfer.nack && xfer.rw;

    always_comb begin
        case (chan)
            chan_x:  xfer.cmd = rtp_cmd_x;
            chan_y:  xfer.cmd = rtp_cmd_y;
            default: xfer.cmd = rtp_cmd_z1;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_gap;
            chan       <= chan_x;
            gap_cnt    <= gap_last;                // first frame needs no gap
            xfer.req   <= 1'b0;
            xfer.rw    <= 1'b0;
            push       <= 1'b0;
            nack_count <= 8'd0;
        end else begin
            push <= 1'b0;
            case (state)
                st_gap: begin
                    if (gap_cnt < gap_last) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else if (enable && !buf_full) begin
                        chan     <= chan_x;
                        xfer.rw  <= 1'b0;
                        xfer.req <= 1'b1;
                        state    <= st_wait;
                    end
                end
                st_issue: begin
                    xfer.req <= 1'b1;
                    state    <= st_wait;
                end
                st_wait: begin
                    if (xfer.done) begin
                        xfer.req <= 1'b0;
                        if (xfer.nack) begin
                            if (nack_count != 8'hff)
                                nack_count <= nack_count + 1'b1;
                            gap_cnt <= '0;
                            state   <= st_gap;
                        end else if (!xfer.rw) begin
                            xfer.rw <= 1'b1;       // command sent, now read it back
                            state   <= st_issue;
                        end else if (chan == chan_z1) begin
                            push    <= 1'b1;       // one cycle after the last done
                            gap_cnt <= '0;
                            state   <= st_gap;
                        end else begin
                            chan    <= (chan == chan_x) ? chan_y : chan_z1;
                            xfer.rw <= 1'b0;
                            state   <= st_issue;
                        end
                    end
                end
                default: state <= st_gap;
            endcase
        end
    end

    // coordinates and the outgoing sample
    always_ff @(posedge clk) begin
        if (rd_ok && chan == chan_x)
            x_q <= xfer.rdata;
        if (rd_ok && chan == chan_y)
            y_q <= xfer.rdata;
        if (rd_ok && chan == chan_z1) begin
            push_data.x       <= x_q;
            push_data.y       <= y_q;
            push_data.z1      <= xfer.rdata;
            push_data.pressed <= (xfer.rdata > press_thresh);
        end
    end

endmodule

//--- rtp_sample_buf.sv
`timescale 1ns/1ps
// sample FIFO with credit based output toward the consumer
// the consumer owns out_credits slots and pulses credit_return once per freed slot
// sample_valid has no ready, each high cycle hands over one entry
module rtp_sample_buf #(
    parameter int unsigned buf_depth   = 4,
    parameter int unsigned out_credits = 2
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  rtp_pkg::rtp_sample_t push_data,
    output logic                 full,
    output logic                 sample_valid,
    output rtp_pkg::rtp_sample_t sample,
    input  logic                 credit_return
);
    import rtp_pkg::*;

    localparam int unsigned aw  = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int unsigned nw  = $clog2(buf_depth + 1);
    localparam int unsigned crw = $clog2(out_credits + 1);

    rtp_sample_t    mem [buf_depth];
    logic [aw-1:0]  wr_ptr;
    logic [aw-1:0]  rd_ptr;
    logic [nw-1:0]  count;
    logic [crw-1:0] credits;
    logic           wr_en;
    logic           send;

    function automatic logic [aw-1:0] ptr_inc(input logic [aw-1:0] p);
        ptr_inc = (p == aw'(buf_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full         = (count == nw'(buf_depth));   // no free entry left
    assign wr_en        = push && !full;
    assign send         = (count != '0) && (credits != '0);
    assign sample_valid = send;
    assign sample       = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= crw'(out_credits);
        end else begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (send)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            // a return in the same cycle as a send cancels out
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= push_data;
    end

endmodule

//--- rtp_top.sv
`timescale 1ns/1ps
// NS2009 touch panel polling front end on I2C
// scl and sda are split, oe = 1 pulls the line low and *_in reads the wired-AND bus
// external pull-ups needed, clock stretching and multi-master are not handled
// samples leave under credit flow control, out_credits must match the consumer
module rtp_top #(
    parameter int unsigned clk_div      = 62,       // ~100 kHz scl from 25 MHz
    parameter int unsigned poll_gap     = 25000,
    parameter logic [11:0] press_thresh = 12'h200,
    parameter int unsigned buf_depth    = 4,
    parameter int unsigned out_credits  = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        enable,
    output logic        scl_oe,
    output logic        sda_oe,
    input  logic        scl_in,
    input  logic        sda_in,
    output logic        sample_valid,
    output logic [11:0] sample_x,
    output logic [11:0] sample_y,
    output logic [11:0] sample_z1,
    output logic        sample_pressed,
    input  logic        credit_return,
    output logic        busy,
    output logic [7:0]  nack_count
);
    import rtp_pkg::*;

    rtp_sample_t push_data;
    rtp_sample_t sample;
    logic        push;
    logic        buf_full;
    logic        tick;
    logic        mid_tick;

    rtp_xfer_if xfer ();

    rtp_tick_gen #(
        .clk_div (clk_div)
    ) u_tick_gen (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (busy),
        .tick     (tick),
        .mid_tick (mid_tick)
    );

    rtp_i2c_master u_i2c_master (
        .clk      (clk),
        .arst_n   (arst_n),
        .xfer     (xfer.mst),
        .tick     (tick),
        .mid_tick (mid_tick),
        .busy     (busy),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe),
        .scl_in   (scl_in),
        .sda_in   (sda_in)
    );

    rtp_poll_seq #(
        .poll_gap     (poll_gap),
        .press_thresh (press_thresh)
    ) u_poll_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .enable     (enable),
        .xfer       (xfer.seq),
        .push       (push),
        .push_data  (push_data),
        .buf_full   (buf_full),
        .nack_count (nack_count)
    );

    rtp_sample_buf #(
        .buf_depth   (buf_depth),
        .out_credits (out_credits)
    ) u_sample_buf (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (push),
        .push_data     (push_data),
        .full          (buf_full),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .credit_return (credit_return)
    );

    // flatten the sample for the pins
    assign sample_x       = sample.x;
    assign sample_y       = sample.y;
    assign sample_z1      = sample.z1;
    assign sample_pressed = sample.pressed;

endmodule

//--- tb_ns2009_model.sv
`timescale 1ns/1ps
// behavioral NS2009 slave on the wired-AND bus, clocked by the system clock
// never stretches SCL, so scl_in is just the DUT release
// protocol violations are printed and counted in err_count
module tb_ns2009_model (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        scl_oe,
    input  logic        sda_oe,
    output logic        scl_in,
    output logic        sda_in,
    input  logic [11:0] x_val,
    input  logic [11:0] y_val,
    input  logic [11:0] z1_val,
    input  logic        nack_next,     // NACK the next address byte
    output logic        frame_done,    // one cycle per completed x, y, z1 frame
    output logic [35:0] frame_xyz,     // {x, y, z1} of that frame
    output int          err_count
);
    import rtp_pkg::*;

    logic        scl;
    logic        sda;
    logic        scl_q;
    logic        sda_q;
    logic        m_sda_oe;             // model pulls sda low
    logic        in_xfer;
    logic        rd;
    logic        addr_nack;
    logic        nack_pend;
    logic [3:0]  pos;                  // bit within byte, 8 is the ack slot
    logic [1:0]  byte_idx;
    logic [7:0]  sh;
    logic [15:0] rd_word;              // 12-bit result, low nibble padded with 0
    logic [11:0] cap_x;
    logic [11:0] cap_y;
    logic [3:0]  idx;
    rtp_chan_e   exp_chan;
    rtp_chan_e   cur_chan;

    assign scl    = !scl_oe;
    assign sda    = !(sda_oe || m_sda_oe);
    assign scl_in = scl;
    assign sda_in = sda;
    assign idx    = (byte_idx == 2'd1) ? 4'd15 - pos : 4'd7 - pos;

    function automatic logic [7:0] chan_cmd(input rtp_chan_e c);
        case (c)
            chan_x:  chan_cmd = rtp_cmd_x;
            chan_y:  chan_cmd = rtp_cmd_y;
            default: chan_cmd = rtp_cmd_z1;
        endcase
    endfunction

    function automatic logic [11:0] chan_val(input rtp_chan_e c);
        case (c)
            chan_x:  chan_val = x_val;
            chan_y:  chan_val = y_val;
            default: chan_val = z1_val;
        endcase
    endfunction

    task automatic report_violation(input string msg);
        $display("FAILED at %0t: bus protocol, %s", $time, msg);
        err_count = err_count + 1;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            m_sda_oe   <= 1'b0;
            in_xfer    <= 1'b0;
            rd         <= 1'b0;
            addr_nack  <= 1'b0;
            nack_pend  <= 1'b0;
            pos        <= 4'd0;
            byte_idx   <= 2'd0;
            exp_chan   <= chan_x;
            cur_chan   <= chan_x;
            frame_done <= 1'b0;
            err_count = 0;
        end else begin
            frame_done <= 1'b0;
            scl_q      <= scl;
            sda_q      <= sda;
            if (nack_next)
                nack_pend <= 1'b1;

            // sda moving while scl stays high is a start or a stop
            if (scl_q && scl && sda != sda_q) begin
                if (!sda) begin
                    assert (!in_xfer) else report_violation("start inside a transfer");
                    in_xfer   <= 1'b1;
                    pos       <= 4'd0;
                    byte_idx  <= 2'd0;
                    addr_nack <= 1'b0;
                end else begin
                    // the stop's own scl high was already taken as bit 0
                    assert (in_xfer && pos == 4'd1)
                        else report_violation("sda rose while scl high inside a byte");
                    in_xfer  <= 1'b0;
                    m_sda_oe <= 1'b0;
                    if (rd && !addr_nack && byte_idx == 2'd3 && cur_chan == chan_z1) begin
                        frame_done <= 1'b1;
                        frame_xyz  <= {cap_x, cap_y, rd_word[15:4]};
                    end
                end
            end

            // scl rising, capture
            if (in_xfer && !scl_q && scl) begin
                if (pos == 4'd8) begin
                    if (rd && byte_idx != 2'd0)     // ack high byte, nack low byte
                        assert (sda == (byte_idx == 2'd2))
                            else report_violation("wrong master ack after read byte");
                    pos      <= 4'd0;
                    byte_idx <= byte_idx + 2'd1;
                end else begin
                    sh  <= {sh[6:0], sda};
                    pos <= pos + 4'd1;
                    if (pos == 4'd7 && byte_idx == 2'd0) begin
                        assert ({sh[6:0], sda} == 8'h90 || {sh[6:0], sda} == 8'h91)
                            else report_violation("address byte not 0x90 or 0x91");
                        rd <= sda;
                        if (nack_pend) begin
                            addr_nack <= 1'b1;
                            nack_pend <= 1'b0;
                            exp_chan  <= chan_x;    // sequencer restarts the frame
                        end
                    end
                    if (pos == 4'd7 && byte_idx == 2'd1 && !rd) begin
                        assert ({sh[6:0], sda} == chan_cmd(exp_chan))
                            else report_violation("command byte out of x, y, z1 order");
                        cur_chan <= exp_chan;
                        rd_word  <= {chan_val(exp_chan), 4'h0};
                        if (exp_chan == chan_x)
                            cap_x <= x_val;
                        if (exp_chan == chan_y)
                            cap_y <= y_val;
                        exp_chan <= (exp_chan == chan_x) ? chan_y :
                                    (exp_chan == chan_y) ? chan_z1 : chan_x;
                    end
                end
            end

            // scl falling, set up the next bit while scl is low
            if (in_xfer && scl_q && !scl) begin
                if (addr_nack)
                    m_sda_oe <= 1'b0;
                else if (pos == 4'd8)
                    m_sda_oe <= (byte_idx == 2'd0) || (byte_idx == 2'd1 && !rd);
                else if (rd && (byte_idx == 2'd1 || byte_idx == 2'd2))
                    m_sda_oe <= !rd_word[idx];  // data msb first
                else
                    m_sda_oe <= 1'b0;
            end
        end
    end

endmodule

//--- tb_rtp.sv
`timescale 1ns/1ps
// testbench for rtp_top with the NS2009 bus model and a credit consumer
// clk_div 4 keeps frames short, the run ends on a cycle limit of 40 frames
module tb_rtp;

    // 4 clocks per quarter, 4 quarters per bit, write 20 bits and read 29 bits
    localparam int frame_cycles = 3 * (4 * 4 * (20 + 29) + 8) + 10 + 8;
    localparam int max_cycles   = 40 * frame_cycles;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        enable;
    logic        credit_return;
    logic        scl_oe;
    logic        sda_oe;
    logic        scl_in;
    logic        sda_in;
    logic        sample_valid;
    logic [11:0] sample_x;
    logic [11:0] sample_y;
    logic [11:0] sample_z1;
    logic        sample_pressed;
    logic        busy;
    logic [7:0]  nack_count;
    logic        nack_next;
    logic [11:0] x_val  = 12'h123;
    logic [11:0] y_val  = 12'h456;
    logic [11:0] z1_val = 12'h7a0;    // first frame pressed
    logic        frame_done;
    logic [35:0] frame_xyz;
    int          proto_errs;

    logic [35:0] exp_q[$];            // expected {x, y, z1}, oldest first
    int          errors   = 0;
    int          sent     = 0;        // sample_valid pulses
    int          returned = 0;        // credit_return pulses
    int          frames   = 0;        // frames completed on the bus
    int          cycles   = 0;
    bit          hold     = 1'b0;     // withhold credit returns
    bit          hi_z     = 1'b0;

    always #20 clk = ~clk;

    rtp_top #(
        .clk_div      (4),
        .poll_gap     (10),
        .press_thresh (12'h200),
        .buf_depth    (4),
        .out_credits  (2)
    ) u_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .enable         (enable),
        .scl_oe         (scl_oe),
        .sda_oe         (sda_oe),
        .scl_in         (scl_in),
        .sda_in         (sda_in),
        .sample_valid   (sample_valid),
        .sample_x       (sample_x),
        .sample_y       (sample_y),
        .sample_z1      (sample_z1),
        .sample_pressed (sample_pressed),
        .credit_return  (credit_return),
        .busy           (busy),
        .nack_count     (nack_count)
    );

    tb_ns2009_model u_model (
        .clk        (clk),
        .arst_n     (arst_n),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .x_val      (x_val),
        .y_val      (y_val),
        .z1_val     (z1_val),
        .nack_next  (nack_next),
        .frame_done (frame_done),
        .frame_xyz  (frame_xyz),
        .err_count  (proto_errs)
    );

    task automatic flag_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic wait_sent(input int target);
        while (sent < target)
            @(posedge clk);
    endtask

    // new panel readings, z1 alternates across the threshold
    task automatic pick_values();
        x_val  = 12'($urandom);
        y_val  = 12'($urandom);
        z1_val = hi_z ? 12'($urandom_range(4095, 513)) : 12'($urandom_range(512, 0));
        hi_z   = !hi_z;
    endtask

    always @(posedge clk) begin
        if (frame_done) begin
            #2;
            pick_values();
        end
    end

    // scoreboard, outputs sampled at the edge before they change
    always @(posedge clk) begin : monitor
        logic [35:0] exp;
        if (frame_done) begin
            exp_q.push_back(frame_xyz);
            frames++;
        end
        if (sample_valid) begin
            sent++;
            assert (sent <= 2 + returned)
                else flag_error($sformatf("sample %0d sent with only %0d credits returned",
                                          sent, returned));
            if (exp_q.size() == 0) begin
                flag_error("sample_valid with no completed frame behind it");
            end else begin
                exp = exp_q.pop_front();
                assert ({sample_x, sample_y, sample_z1} == exp)
                    else flag_error($sformatf("got x=%h y=%h z1=%h, expected x=%h y=%h z1=%h",
                                              sample_x, sample_y, sample_z1,
                                              exp[35:24], exp[23:12], exp[11:0]));
                assert (sample_pressed == (exp[11:0] > 12'h200))
                    else flag_error($sformatf("pressed %b for z1 %h",
                                              sample_pressed, exp[11:0]));
            end
        end
        if (credit_return)
            returned++;    // counts toward the next cycle
    end

    // consumer frees each slot after a random delay unless held
    initial begin : consumer
        int pend;
        pend          = 0;
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            if (sample_valid)
                pend++;
            #2;
            if (!hold && pend > 0 && ($urandom % 2) == 0) begin
                credit_return = 1'b1;
                pend--;
            end else begin
                credit_return = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout, run still going after %0d cycles", max_cycles);
            $display("errors: %0d check, %0d protocol", errors, proto_errs);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin : stimulus
        int         target;
        logic [7:0] nack_before;
        void'($urandom(32'h0a2cf3c6));
        arst_n    = 1'b0;
        enable    = 1'b0;
        nack_next = 1'b0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;

        // idle after reset while enable is low
        repeat (3) begin
            @(posedge clk);
            assert (!scl_oe && !sda_oe && !sample_valid && !busy && nack_count == 8'd0)
                else flag_error("outputs not idle after reset");
        end
        #2 enable = 1'b1;
        wait_sent(4);

        // withhold credits until the FIFO and sequencer stall
        #1 hold = 1'b1;
        while (exp_q.size() < 4)
            @(posedge clk);
        repeat (2 * frame_cycles) @(posedge clk);
        assert (exp_q.size() == 4)
            else flag_error($sformatf("%0d frames pending during stall, expected 4",
                                      exp_q.size()));
        #1 hold = 1'b0;
        target = frames + 2;
        wait_sent(target);

        // one forced address NACK
        nack_before = nack_count;
        #2 nack_next = 1'b1;
        @(posedge clk);
        #2 nack_next = 1'b0;
        while (nack_count == nack_before)
            @(posedge clk);
        target = frames + 1;
        while (frames < target)
            @(posedge clk);
        wait_sent(target);
        assert (nack_count == nack_before + 8'd1)
            else flag_error($sformatf("nack_count %0d after one NACK, expected %0d",
                                      nack_count, nack_before + 8'd1));

        // drain whatever frame is in flight
        #2 enable = 1'b0;
        repeat (frame_cycles) @(posedge clk);
        wait_sent(frames);
        assert (exp_q.size() == 0) else flag_error("expected samples never delivered");

        $display("errors: %0d check, %0d protocol, %0d samples", errors, proto_errs, sent);
        if (errors == 0 && proto_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- list.f
rtp_pkg.sv
rtp_xfer_if.sv
rtp_tick_gen.sv
rtp_i2c_master.sv
rtp_poll_seq.sv
rtp_sample_buf.sv
rtp_top.sv
tb_ns2009_model.sv
tb_rtp.sv

//--- Makefile
# Verilator build and run of the NS2009 poller testbench

SRCS := $(shell grep -v '^+' list.f)

obj_dir/Vtb_rtp: list.f $(SRCS)
	verilator --binary --assert --top-module tb_rtp -f list.f -Mdir obj_dir

run: obj_dir/Vtb_rtp
	./obj_dir/Vtb_rtp | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
